//--- Makefile
SIM      ?= verilator
SIMFLAGS ?= --binary --timing --assert --timescale 1ns/10ps -j 0
TOP      ?= sifhTb
FILELIST ?= all.f
BUILD    ?= obj_dir
PASS_MSG  = *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

# the run passes only when the pass message shows up in the output
test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

//--- all.f
+incdir+include
design/sifhPkg.sv
design/stageIf.sv
design/sampleFilter.sv
design/histBuilder.sv
design/peakTracker.sv
design/windowCalc.sv
design/sifhTop.sv
bench/clockGen.sv
bench/sifhTb_asserts.sv
bench/sifhTb.sv

//--- bench/clockGen.sv
/*
 * testbench clock at a 4 ns period
 * active low reset held for 4 cycles
 */

`timescale 1ns/10ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic combin_res
);

    // half period 2 ns
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // release just after an edge
    initial begin
        combin_res = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        combin_res = 1'b1;
    end

endmodule

`default_nettype wire

//--- bench/sifhTb.sv
/*
 * testbench for the SiFH pipeline
 * random clustered stimulus, reference model, compare tasks, watchdog
 */

`timescale 1ns/10ps
`default_nettype none
`include "sifh_params.svh"

module sifhTb import sifhPkg::*; ();

    localparam int SAMPLES  = `ACQ_NUM * `PIXELS * `DATA_NUM;
    localparam int BINS     = 1 << `NB;
    localparam int RANGE    = 1 << `NP;
    localparam int SB       = 1 << (`NB - 1);
    localparam int MAX_CNT  = (1 << `COUNT_W) - 1;
    localparam int PAIRS    = 4;
    localparam int PASSES   = 2 * PAIRS;
    localparam int WATCHDOG = PASSES * (SAMPLES + 20);

    // per-pixel data kinds
    localparam int CLUSTER   = 0;
    localparam int SINGLE    = 1;
    localparam int FAR_NOISE = 2;
    localparam int WIN_FLOOR = 3;

    logic  clk;
    logic  combin_res;
    logic  sampleValid;
    timeT  sampleTime;
    logic  ready;
    logic  resultValid;
    pixelT resultPixel;
    timeT  resultTime;

    int    seed;
    // true arrival time and data kind per pixel
    int    trueT    [`PIXELS];
    int    pixMode  [`PIXELS];
    // one pass of samples in arrival order
    int    stream   [SAMPLES];
    // model state
    int    winStart [`PIXELS];
    int    peakBin  [`PIXELS];
    int    expTime  [`PIXELS];
    // collected result beats
    pixelT gotPix   [$];
    timeT  gotTime  [$];

    clockGen clkSrc (
        .clk        (clk),
        .combin_res (combin_res)
    );

    sifhTop UUT (
        .clk         (clk),
        .combin_res  (combin_res),
        .sampleValid (sampleValid),
        .sampleTime  (sampleTime),
        .ready       (ready),
        .resultValid (resultValid),
        .resultPixel (resultPixel),
        .resultTime  (resultTime)
    );

    bind sifhTop sifhTb_asserts outputChecks (
        .clk         (clk),
        .combin_res  (combin_res),
        .ready       (ready),
        .resultValid (resultValid),
        .resultPixel (resultPixel),
        .resultTime  (resultTime)
    );

    //****************************************
    // error handling and compares
    //****************************************
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkTime(input string name, input timeT expected, input timeT actual);
        if (actual !== expected) begin
            abortRun($sformatf("[FAIL] %s: expected time %0d, actual %0d",
                name, expected, actual));
        end
    endtask

    task automatic checkPixel(input string name, input pixelT expected, input pixelT actual);
        if (actual !== expected) begin
            abortRun($sformatf("[FAIL] %s: expected pixel %0d, actual %0d",
                name, expected, actual));
        end
    endtask

    //****************************************
    // stimulus generation
    //****************************************
    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // small spread, kept inside the timestamp range
    function automatic int clusterAround(input int center);
        int t;
        t = center + randBelow(7) - 3;
        if (t < 0) begin
            t = 0;
        end else if (t > RANGE - 1) begin
            t = RANGE - 1;
        end
        return t;
    endfunction

    function automatic int drawSample(input int pix, input bit fine);
        int t;
        case (pixMode[pix])
            SINGLE: t = trueT[pix];
            FAR_NOISE: begin
                // mostly half a range away in the fine pass
                if (fine && randBelow(4) != 0) begin
                    t = (trueT[pix] + RANGE / 2) % RANGE;
                end else begin
                    t = clusterAround(trueT[pix]);
                end
            end
            WIN_FLOOR: begin
                // fine data near the bottom of a window pinned at the top
                if (fine) begin
                    t = clusterAround(RANGE - 2 * SB + 4);
                end else begin
                    t = clusterAround(trueT[pix]);
                end
            end
            default: begin
                // uniform background now and then
                if (randBelow(8) == 0) begin
                    t = randBelow(RANGE);
                end else begin
                    t = clusterAround(trueT[pix]);
                end
            end
        endcase
        return t;
    endfunction

    // 0 random, 1 near the range ends, 2 far noise on pixel 2, 3 one bin on pixel 1
    task automatic setupPair(input int kind);
        for (int p = 0; p < `PIXELS; p++) begin
            pixMode[p] = CLUSTER;
            if (kind != 1) begin
                trueT[p] = randBelow(RANGE);
            end else if (p % 2 == 0) begin
                trueT[p] = randBelow(8);
            end else begin
                trueT[p]   = RANGE - 1 - randBelow(8);
                pixMode[p] = WIN_FLOOR;
            end
        end
        if (kind == 2) begin
            pixMode[2] = FAR_NOISE;
        end
        if (kind == 3) begin
            pixMode[1] = SINGLE;
        end
    endtask

    // rounds, then pixels, then samples
    task automatic buildStream(input bit fine);
        for (int idx = 0; idx < SAMPLES; idx++) begin
            stream[idx] = drawSample((idx / `DATA_NUM) % `PIXELS, fine);
        end
    endtask

    //****************************************
    // reference model
    //****************************************
    function automatic int clampWindow(input int coarsePeak);
        int center;
        int start;
        center = coarsePeak * (RANGE / BINS);
        if (center <= SB) begin
            start = 0;
        end else if (center + SB > RANGE - 1) begin
            start = RANGE - 2 * SB;
        end else begin
            start = center - SB;
        end
        return start;
    endfunction

    task automatic modelPass(input bit fine);
        int cnt  [`PIXELS][BINS];
        int best [`PIXELS];
        int pix;
        int bin;
        int off;
        bit hit;
        for (int p = 0; p < `PIXELS; p++) begin
            best[p]    = 0;
            peakBin[p] = 0;
            for (int b = 0; b < BINS; b++) begin
                cnt[p][b] = 0;
            end
        end
        for (int idx = 0; idx < SAMPLES; idx++) begin
            pix = (idx / `DATA_NUM) % `PIXELS;
            if (fine) begin
                off = stream[idx] - winStart[pix];
                hit = (off >= 0) && (off < 2 * SB);
                bin = off;
            end else begin
                hit = 1'b1;
                bin = stream[idx] / (RANGE / BINS);
            end
            if (hit) begin
                // saturating count, strict greater moves the peak
                if (cnt[pix][bin] < MAX_CNT) begin
                    cnt[pix][bin] = cnt[pix][bin] + 1;
                end
                if (cnt[pix][bin] > best[pix]) begin
                    best[pix]    = cnt[pix][bin];
                    peakBin[pix] = bin;
                end
            end
        end
        for (int p = 0; p < `PIXELS; p++) begin
            if (fine) begin
                expTime[p] = winStart[p] + peakBin[p];
            end else begin
                winStart[p] = clampWindow(peakBin[p]);
            end
        end
    endtask

    //****************************************
    // driving and checking
    //****************************************
    task automatic waitReady();
        while (ready !== 1'b1) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic driveStream();
        for (int idx = 0; idx < SAMPLES; idx++) begin
            if (ready !== 1'b1) begin
                sampleValid = 1'b0;
                waitReady();
            end
            sampleValid = 1'b1;
            sampleTime  = timeT'(stream[idx]);
            @(posedge clk);
            #1;
        end
        sampleValid = 1'b0;
    endtask

    // one coarse pass, then one fine pass on fresh samples
    task automatic runPair(input string name);
        gotPix.delete();
        gotTime.delete();
        buildStream(1'b0);
        modelPass(1'b0);
        driveStream();
        waitReady();
        if (gotPix.size() != 0) begin
            abortRun($sformatf("%s: result beats came out after a coarse pass", name));
        end
        buildStream(1'b1);
        modelPass(1'b1);
        driveStream();
        waitReady();
        if (gotPix.size() != `PIXELS) begin
            abortRun($sformatf("%s: expected %0d result beats after the fine pass, got %0d",
                name, `PIXELS, gotPix.size()));
        end
        for (int p = 0; p < `PIXELS; p++) begin
            checkPixel($sformatf("%s, beat %0d", name, p), pixelT'(p), gotPix[p]);
            checkTime($sformatf("%s, pixel %0d", name, p), timeT'(expTime[p]), gotTime[p]);
        end
    endtask

    // results sampled away from the driving edge
    always @(negedge clk) begin
        if (combin_res && resultValid) begin
            gotPix.push_back(resultPixel);
            gotTime.push_back(resultTime);
        end
    end

    // bound property failures end the run as well
    always @(negedge clk) begin
        if (UUT.outputChecks.failCount != 0) begin
            abortRun("a concurrent assertion on the top level failed");
        end
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        abortRun("watchdog expired before all frame pairs finished");
    end

    initial begin
        sampleValid = 1'b0;
        sampleTime  = '0;
        seed        = 32;
        wait (combin_res === 1'b1);
        @(posedge clk);
        #1;
        if (ready !== 1'b1 || resultValid !== 1'b0) begin
            abortRun("ready or resultValid not at the idle value after reset");
        end
        setupPair(0);
        runPair("clustered");
        setupPair(1);
        runPair("window clamp");
        setupPair(2);
        runPair("out-of-window noise");
        // more than 1 pair also shows the lazy clear works
        setupPair(3);
        runPair("single bin");
        if (UUT.outputChecks.failCount != 0) begin
            abortRun("a concurrent assertion on the top level failed");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- bench/sifhTb_asserts.sv
/*
 * concurrent checks on the SiFH top level
 * turnaround length, result order, known outputs
 */

`timescale 1ns/10ps
`default_nettype none
`include "sifh_params.svh"

module sifhTb_asserts import sifhPkg::*; (
    input logic  clk,
    input logic  combin_res,
    input logic  ready,
    input logic  resultValid,
    input pixelT resultPixel,
    input timeT  resultTime
);

    // walk over pixels plus the stage latency
    localparam int STALL_MAX = `PIXELS + 4;

    logic       readyQ;
    // phase of the pass in flight or draining
    logic       passIsFine;
    logic [7:0] lowCycles;
    // number of property failures so far
    int         failCount;

    initial begin
        failCount = 0;
    end

    //****************************************
    // phase and stall tracking
    //****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            readyQ     <= 1'b1;
            passIsFine <= 1'b0;
            lowCycles  <= '0;
        end else begin
            readyQ <= ready;
            // ready back high means the next pass has begun
            if (ready && !readyQ) begin
                passIsFine <= !passIsFine;
            end
            lowCycles <= ready ? '0 : lowCycles + 1'b1;
        end
    end

    //****************************************
    // properties
    //****************************************
    // coarse drain only moves windows
    noCoarseResult: assert property (@(posedge clk) disable iff (!combin_res)
        (!ready && !passIsFine) |-> !resultValid)
        else begin
            failCount = failCount + 1;
            $error("result beat during a coarse turnaround");
        end

    stallBounded: assert property (@(posedge clk) disable iff (!combin_res)
        lowCycles <= 8'(STALL_MAX))
        else begin
            failCount = failCount + 1;
            $error("ready stayed low too long");
        end

    // results start at pixel 0
    firstPixel: assert property (@(posedge clk) disable iff (!combin_res)
        (resultValid && !$past(resultValid)) |-> (resultPixel == '0))
        else begin
            failCount = failCount + 1;
            $error("first result beat is not pixel 0");
        end

    pixelStep: assert property (@(posedge clk) disable iff (!combin_res)
        (resultValid && $past(resultValid))
            |-> (resultPixel == pixelT'($past(resultPixel) + 1'b1)))
        else begin
            failCount = failCount + 1;
            $error("result pixel did not step by one");
        end

    knownOutputs: assert property (@(posedge clk) disable iff (!combin_res)
        !$isunknown({ready, resultValid, resultPixel, resultTime}))
        else begin
            failCount = failCount + 1;
            $error("top level output is unknown");
        end

endmodule

`default_nettype wire

//--- design/histBuilder.sv
/*
 * stage 2, histogram builder
 * per-pixel count memory with lazy clear and saturating increment
 */

`timescale 1ns/10ps
`default_nettype none
`include "sifh_params.svh"

module histBuilder import sifhPkg::*; (
    input  logic clk,
    input  logic combin_res,
    stageIf.dst  inS,
    stageIf.src  outS
);

    localparam int ADDR_W = $bits(pixelT) + `NB;
    localparam int DEPTH  = `PIXELS * (1 << `NB);

    // counts, pixel in the upper address bits
    countT             histMem [DEPTH];
    // entry holds a count of this pass
    logic [DEPTH-1:0]  entryValid;

    logic [ADDR_W-1:0] entryAddr;
    logic              doUpdate;
    countT             curCount;
    countT             newCount;

    assign entryAddr = {inS.pixel, inS.payload};
    assign doUpdate  = inS.valid && inS.hit;

    // stale entries read as empty
    assign curCount = entryValid[entryAddr] ? histMem[entryAddr] : '0;
    // hold at all ones
    assign newCount = (&curCount) ? curCount : curCount + 1'b1;

    //****************************************
    // memory write
    //****************************************
    always_ff @(posedge clk) begin
        if (doUpdate) begin
            histMem[entryAddr] <= newCount;
        end
    end

    // drop every valid bit at pass end instead of sweeping
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            entryValid <= '0;
        end else if (inS.valid && inS.lastOfPass) begin
            entryValid <= '0;
        end else if (doUpdate) begin
            entryValid[entryAddr] <= 1'b1;
        end
    end

    //****************************************
    // forward beat with new count
    //****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            outS.valid      <= 1'b0;
            outS.hit        <= 1'b0;
            outS.lastOfPass <= 1'b0;
        end else begin
            outS.valid      <= inS.valid;
            outS.hit        <= doUpdate;
            outS.lastOfPass <= inS.valid && inS.lastOfPass;
        end
    end

    always_ff @(posedge clk) begin
        outS.pixel         <= inS.pixel;
        outS.fine          <= inS.fine;
        outS.payload.bin   <= inS.payload;
        // misses carry no count
        outS.payload.count <= doUpdate ? newCount : '0;
    end

endmodule

`default_nettype wire

//--- design/peakTracker.sv
/*
 * stage 3, peak detector
 * running per-pixel maximum and peak bin, serial publish at pass end
 */

`timescale 1ns/10ps
`default_nettype none
`include "sifh_params.svh"

module peakTracker import sifhPkg::*; (
    input  logic clk,
    input  logic combin_res,
    stageIf.dst  inS,
    stageIf.src  outS
);

    // best count and its bin per pixel
    countT    maxCnt  [`PIXELS];
    binT      peakBin [`PIXELS];

    // publish walk over all pixels
    logic     walking;
    pixelT    walkIdx;
    logic     walkFine;
    logic     walkLast;

    binCountT inBeat;
    logic     newPeak;

    assign inBeat   = inS.payload;
    // strictly greater, so first bin to reach a count keeps it
    assign newPeak  = inS.valid && inS.hit && (inBeat.count > maxCnt[inS.pixel]);
    assign walkLast = (walkIdx == pixelT'(`PIXELS - 1));

    //****************************************
    // tracking and walk control
    //****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < `PIXELS; i++) begin
                maxCnt[i]  <= '0;
                peakBin[i] <= '0;
            end
            walking  <= 1'b0;
            walkIdx  <= '0;
            walkFine <= 1'b0;
        end else if (walking) begin
            // published pixel starts fresh for the next pass
            maxCnt[walkIdx]  <= '0;
            peakBin[walkIdx] <= '0;
            walkIdx          <= walkIdx + 1'b1;
            if (walkLast) begin
                walking <= 1'b0;
            end
        end else begin
            if (newPeak) begin
                maxCnt[inS.pixel]  <= inBeat.count;
                peakBin[inS.pixel] <= inBeat.bin;
            end
            // last update lands first, walk starts next cycle
            if (inS.valid && inS.lastOfPass) begin
                walking  <= 1'b1;
                walkIdx  <= '0;
                walkFine <= inS.fine;
            end
        end
    end

    //****************************************
    // published beats
    //****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            outS.valid      <= 1'b0;
            outS.hit        <= 1'b0;
            outS.lastOfPass <= 1'b0;
        end else begin
            outS.valid      <= walking;
            outS.hit        <= walking;
            outS.lastOfPass <= walking && walkLast;
        end
    end

    // empty pixel gives bin 0
    always_ff @(posedge clk) begin
        outS.pixel   <= walkIdx;
        outS.fine    <= walkFine;
        outS.payload <= peakBin[walkIdx];
    end

endmodule

`default_nettype wire

//--- design/sampleFilter.sv
/*
 * stage 1, data filter
 * sample/pixel/round counters, coarse/fine phase, window test, ready
 */

`timescale 1ns/10ps
`default_nettype none
`include "sifh_params.svh"

module sampleFilter import sifhPkg::*; (
    input  logic   clk,
    input  logic   combin_res,
    input  logic   sampleValid,
    input  timeT   sampleTime,
    output logic   ready,
    input  winArrT winLo,
    input  logic   done,
    stageIf.src    outS
);

    localparam int SAMPLE_W = ($clog2(`DATA_NUM) < 1) ? 1 : $clog2(`DATA_NUM);
    localparam int ROUND_W  = ($clog2(`ACQ_NUM) < 1) ? 1 : $clog2(`ACQ_NUM);

    // position inside the pass
    logic [SAMPLE_W-1:0] sampleCnt;
    pixelT               pixelCnt;
    logic [ROUND_W-1:0]  roundCnt;
    // 0 coarse, 1 fine
    logic                finePass;

    logic                accept;
    logic                lastSample;
    logic                lastPixel;
    logic                lastRound;
    logic                passEnd;
    logic [`NP:0]        winDiff;
    logic                inWindow;
    binT                 binAddr;
    logic                sampleHit;

    //****************************************
    // window test and bin address
    //****************************************
    assign accept     = sampleValid && ready;
    assign lastSample = (sampleCnt == SAMPLE_W'(`DATA_NUM - 1));
    assign lastPixel  = (pixelCnt == pixelT'(`PIXELS - 1));
    assign lastRound  = (roundCnt == ROUND_W'(`ACQ_NUM - 1));
    assign passEnd    = accept && lastSample && lastPixel && lastRound;

    // offset from window start, msb set means below the window
    assign winDiff  = {1'b0, sampleTime} - {1'b0, winLo[pixelCnt]};
    assign inWindow = !winDiff[`NP] && (winDiff[`NP-1:0] < WIN_SPAN);

    // coarse uses top NB bits, fine uses the offset
    assign binAddr   = finePass ? winDiff[`NB-1:0] : sampleTime[`NP-1 -: `NB];
    assign sampleHit = !finePass || inWindow;

    //****************************************
    // counters and phase
    //****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            pixelCnt  <= '0;
            roundCnt  <= '0;
            finePass  <= 1'b0;
        end else if (accept) begin
            sampleCnt <= lastSample ? '0 : sampleCnt + 1'b1;
            if (lastSample) begin
                pixelCnt <= lastPixel ? '0 : pixelCnt + 1'b1;
                if (lastPixel) begin
                    roundCnt <= lastRound ? '0 : roundCnt + 1'b1;
                end
            end
            // next pass switches resolution
            if (passEnd) begin
                finePass <= !finePass;
            end
        end
    end

    // input stalls from last sample until windows are settled
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            ready <= 1'b1;
        end else if (passEnd) begin
            ready <= 1'b0;
        end else if (done) begin
            ready <= 1'b1;
        end
    end

    //****************************************
    // outgoing beat
    //****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            outS.valid      <= 1'b0;
            outS.hit        <= 1'b0;
            outS.lastOfPass <= 1'b0;
        end else begin
            outS.valid      <= accept;
            outS.hit        <= accept && sampleHit;
            outS.lastOfPass <= passEnd;
        end
    end

    // qualified by valid downstream
    always_ff @(posedge clk) begin
        outS.pixel   <= pixelCnt;
        outS.fine    <= finePass;
        outS.payload <= binAddr;
    end

endmodule

`default_nettype wire

//--- design/sifhPkg.sv
/*
 * shared types for the SiFH pipeline
 * timestamp, bin, pixel and count types plus window constants
 */

`default_nettype none

package sifhPkg;

    `include "sifh_params.svh"

    //****************************************
    // scalar types
    //****************************************
    typedef logic [`NP-1:0]             timeT;
    typedef logic [`NB-1:0]             binT;
    typedef logic [$clog2(`PIXELS)-1:0] pixelT;
    typedef logic [`COUNT_W-1:0]        countT;

    // bin with its current count, histogram to peak stage
    typedef struct packed {
        binT   bin;
        countT count;
    } binCountT;

    // one window start per pixel
    typedef timeT [`PIXELS-1:0] winArrT;

    //****************************************
    // window constants
    //****************************************
    // SB, half of the fine window
    localparam timeT HALF_SPAN = timeT'(1 << (`NB - 1));
    // full fine window, 2*SB
    localparam timeT WIN_SPAN  = timeT'(1 << `NB);
    // highest legal window start
    localparam timeT WIN_TOP   = timeT'((1 << `NP) - (1 << `NB));

endpackage

`default_nettype wire

//--- design/sifhTop.sv
/*
 * SiFH pipeline top level
 * filter, histogram, peak and window stages with feedback
 */

`timescale 1ns/10ps
`default_nettype none

module sifhTop import sifhPkg::*; (
    input  logic  clk,
    input  logic  combin_res,
    input  logic  sampleValid,
    input  timeT  sampleTime,
    output logic  ready,
    output logic  resultValid,
    output pixelT resultPixel,
    output timeT  resultTime
);

    //****************************************
    // stage links
    //****************************************
    // filter to histogram, bin address
    stageIf #(.payloadT(binT))      filtToHist ();
    // histogram to peak, bin with count
    stageIf #(.payloadT(binCountT)) histToPeak ();
    // peak to window, peak bin per pixel
    stageIf #(.payloadT(binT))      peakToWin  ();

    // feedback from window stage
    winArrT winLo;
    logic   done;

    //****************************************
    // stages
    //****************************************
    sampleFilter filterStage (
        .clk         (clk),
        .combin_res  (combin_res),
        .sampleValid (sampleValid),
        .sampleTime  (sampleTime),
        .ready       (ready),
        .winLo       (winLo),
        .done        (done),
        .outS        (filtToHist)
    );

    histBuilder histStage (
        .clk        (clk),
        .combin_res (combin_res),
        .inS        (filtToHist),
        .outS       (histToPeak)
    );

    peakTracker peakStage (
        .clk        (clk),
        .combin_res (combin_res),
        .inS        (histToPeak),
        .outS       (peakToWin)
    );

    windowCalc winStage (
        .clk         (clk),
        .combin_res  (combin_res),
        .inS         (peakToWin),
        .winLo       (winLo),
        .done        (done),
        .resultValid (resultValid),
        .resultPixel (resultPixel),
        .resultTime  (resultTime)
    );

endmodule

`default_nettype wire

//--- design/stageIf.sv
/*
 * stage-to-stage beat bundle with a typed payload
 * src and dst modports
 */

`timescale 1ns/10ps
`default_nettype none

interface stageIf import sifhPkg::*; #(
    parameter type payloadT = binT
) ();

    // beat present this cycle
    logic    valid;
    // sample counts toward the histogram
    logic    hit;
    // pixel the beat belongs to
    pixelT   pixel;
    // beat is part of a fine pass
    logic    fine;
    // final beat of the pass
    logic    lastOfPass;
    payloadT payload;

    // upstream stage drives everything
    modport src (
        output valid,
        output hit,
        output pixel,
        output fine,
        output lastOfPass,
        output payload
    );

    // downstream stage only samples
    modport dst (
        input valid,
        input hit,
        input pixel,
        input fine,
        input lastOfPass,
        input payload
    );

endinterface

`default_nettype wire

//--- design/windowCalc.sv
/*
 * stage 4, algebraic calculation
 * clamped window start from coarse peak, fine result output, done pulse
 */

`timescale 1ns/10ps
`default_nettype none
`include "sifh_params.svh"

module windowCalc import sifhPkg::*; (
    input  logic   clk,
    input  logic   combin_res,
    stageIf.dst    inS,
    output winArrT winLo,
    output logic   done,
    output logic   resultValid,
    output pixelT  resultPixel,
    output timeT   resultTime
);

    binT          inBin;
    // coarse peak scaled back to timestamp units
    timeT         coarseHigh;
    // one extra bit to see overflow past the range
    logic [`NP:0] topReach;
    timeT         newStart;
    logic         coarseBeat;
    logic         fineBeat;

    assign inBin      = inS.payload;
    assign coarseHigh = {inBin, {(`NP - `NB){1'b0}}};
    assign topReach   = {1'b0, coarseHigh} + {1'b0, HALF_SPAN};
    assign coarseBeat = inS.valid && inS.hit && !inS.fine;
    assign fineBeat   = inS.valid && inS.fine;

    //****************************************
    // window clamp
    //****************************************
    always_comb begin
        if (coarseHigh <= HALF_SPAN) begin
            // pinned to the bottom
            newStart = '0;
        end else if (topReach[`NP]) begin
            // pinned to the top
            newStart = WIN_TOP;
        end else begin
            newStart = coarseHigh - HALF_SPAN;
        end
    end

    //****************************************
    // window store and result
    //****************************************
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            winLo       <= '0;
            done        <= 1'b0;
            resultValid <= 1'b0;
            resultPixel <= '0;
            resultTime  <= '0;
        end else begin
            // pulse on the final pixel of either pass
            done        <= inS.valid && inS.lastOfPass;
            resultValid <= fineBeat;
            if (coarseBeat) begin
                winLo[inS.pixel] <= newStart;
            end
            // fine peak is an offset into this pixel's window
            if (fineBeat) begin
                resultPixel <= inS.pixel;
                resultTime  <= winLo[inS.pixel] + timeT'(inBin);
            end
        end
    end

endmodule

`default_nettype wire

//--- include/sifh_params.svh
/*
 * size macros for the SiFH timing pipeline
 * timestamp and bin widths, frame shape, count width
 */

`ifndef SIFH_PARAMS_SVH
`define SIFH_PARAMS_SVH

// timestamp width in bits
`define NP 8

// bin address width, 2^NB bins per pixel
`define NB 6

// pixels per round
`define PIXELS 4

// samples per pixel per round
`define DATA_NUM 2

// rounds per pass
`define ACQ_NUM 8

// histogram count width, counts saturate at all ones
`define COUNT_W 8

`endif
